//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
TOP       ?= tile_mem_system_tb
FILELIST  ?= tile_mem_system.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- include/tile_cfg.svh
// Tile memory system configuration
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Message field widths
`define TILE_ADDR_WIDTH   32
`define TILE_DATA_WIDTH   64
`define TILE_TAG_WIDTH    4

// Address map
`define TILE_DRAM_BASE    32'h8000_0000
`define TILE_DEV_LSB      20
`define TILE_DEV_WIDTH    4
`define TILE_OFFSET_WIDTH 20
`define TILE_DID_WIDTH    3

// Configuration register offsets
`define TILE_CFG_FREEZE   20'h0_0000
`define TILE_CFG_HOST_DID 20'h0_0008
`define TILE_CFG_MY_DID   20'h0_0010

// CLINT register offsets
`define TILE_CLINT_MSIP     20'h0_0000
`define TILE_CLINT_MTIMECMP 20'h0_4000
`define TILE_CLINT_MTIME    20'h0_BFF8

`define TILE_ORDER_DEPTH  4

`endif

//--- source/cfg_regs.sv
// Configuration registers
`timescale 1ns/1ps
`include "tile_cfg.svh"

module cfg_regs
  (input                                clk_i
   , input                              reset_i
   , input  tile_mem_pkg::mem_msg_s     cmd_i
   , input                              cmd_v_i
   , output logic                       cmd_ready_o
   , output tile_mem_pkg::mem_msg_s     resp_o
   , output logic                       resp_v_o
   , input                              resp_ready_i
   , input  [`TILE_DID_WIDTH-1:0]       my_did_i
   , output logic                       freeze_o
   , output logic [`TILE_DID_WIDTH-1:0] host_did_o
   );

  logic                        accept;
  logic                        is_wr;
  logic [`TILE_DATA_WIDTH-1:0] rd_data;

  assign cmd_ready_o = ~resp_v_o | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_wr       = (cmd_i.hdr.msg_type == tile_mem_pkg::MSG_WR);

  always_comb
  begin
    rd_data = '0;
    if (!is_wr)
      case (cmd_i.hdr.addr.fields.offset)
        `TILE_CFG_FREEZE:   rd_data = `TILE_DATA_WIDTH'(freeze_o);
        `TILE_CFG_HOST_DID: rd_data = `TILE_DATA_WIDTH'(host_did_o);
        `TILE_CFG_MY_DID:   rd_data = `TILE_DATA_WIDTH'(my_did_i);
        default:            rd_data = '0;
      endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_o   <= 1'b1;
      host_did_o <= '0;
      resp_v_o   <= 1'b0;
    end
    else
    begin
      if (accept && is_wr && cmd_i.hdr.addr.fields.offset == `TILE_CFG_FREEZE)
        freeze_o <= cmd_i.data[0];
      if (accept && is_wr && cmd_i.hdr.addr.fields.offset == `TILE_CFG_HOST_DID)
        host_did_o <= cmd_i.data[`TILE_DID_WIDTH-1:0];
      if (accept)
        resp_v_o <= 1'b1;
      else if (resp_ready_i)
        resp_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_o <= '{hdr: cmd_i.hdr, data: rd_data};
  end

endmodule

//--- source/clint_slice.sv
// Core-local interruptor
`timescale 1ns/1ps
`include "tile_cfg.svh"

module clint_slice
  (input                            clk_i
   , input                          reset_i
   , input  tile_mem_pkg::mem_msg_s cmd_i
   , input                          cmd_v_i
   , output logic                   cmd_ready_o
   , output tile_mem_pkg::mem_msg_s resp_o
   , output logic                   resp_v_o
   , input                          resp_ready_i
   , output logic                   timer_irq_o
   , output logic                   software_irq_o
   );

  logic                        accept;
  logic                        is_wr;
  logic [`TILE_DATA_WIDTH-1:0] rd_data;
  logic                        msip_r;
  logic [`TILE_DATA_WIDTH-1:0] mtimecmp_r;
  logic [`TILE_DATA_WIDTH-1:0] mtime_r;

  assign cmd_ready_o = ~resp_v_o | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_wr       = (cmd_i.hdr.msg_type == tile_mem_pkg::MSG_WR);

  always_comb
  begin
    rd_data = '0;
    if (!is_wr)
      case (cmd_i.hdr.addr.fields.offset)
        `TILE_CLINT_MSIP:     rd_data = `TILE_DATA_WIDTH'(msip_r);
        `TILE_CLINT_MTIMECMP: rd_data = mtimecmp_r;
        `TILE_CLINT_MTIME:    rd_data = mtime_r;
        default:              rd_data = '0;
      endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      msip_r     <= 1'b0;
      mtimecmp_r <= '1;
      mtime_r    <= '0;
      resp_v_o   <= 1'b0;
    end
    else
    begin
      if (accept && is_wr && cmd_i.hdr.addr.fields.offset == `TILE_CLINT_MSIP)
        msip_r <= cmd_i.data[0];
      if (accept && is_wr && cmd_i.hdr.addr.fields.offset == `TILE_CLINT_MTIMECMP)
        mtimecmp_r <= cmd_i.data;
      // Free-running time base, a write takes priority over the increment
      if (accept && is_wr && cmd_i.hdr.addr.fields.offset == `TILE_CLINT_MTIME)
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + 1'b1;
      if (accept)
        resp_v_o <= 1'b1;
      else if (resp_ready_i)
        resp_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_o <= '{hdr: cmd_i.hdr, data: rd_data};
  end

  assign software_irq_o = msip_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);

endmodule

//--- source/mem_cmd_dispatch.sv
// Memory command dispatch
`timescale 1ns/1ps
`include "tile_cfg.svh"

module mem_cmd_dispatch
  (input                             clk_i
   , input                           reset_i
   , input  tile_mem_pkg::mem_msg_s  cmd_i
   , input                           cmd_v_i
   , output logic                    cmd_ready_o
   , output tile_mem_pkg::mem_msg_s  dev_cmd_o
   , output logic [3:0]              dev_v_o
   , input  [3:0]                    dev_ready_i
   , output logic                    ord_v_o
   , output tile_dev_pkg::dev_id_e   ord_dev_o
   , input                           ord_ready_i
   );

  tile_dev_pkg::dev_id_e sel;
  logic                  is_dram;
  logic                  out_free;
  logic                  accept;
  logic [3:0]            dev_v_r;

  assign is_dram = (cmd_i.hdr.addr.word >= `TILE_DRAM_BASE);

  always_comb
  begin
    if (is_dram)
      sel = tile_dev_pkg::DEV_MEM;
    else
      case (cmd_i.hdr.addr.fields.dev)
        tile_dev_pkg::DEV_CODE_MEM:   sel = tile_dev_pkg::DEV_MEM;
        tile_dev_pkg::DEV_CODE_CFG:   sel = tile_dev_pkg::DEV_CFG;
        tile_dev_pkg::DEV_CODE_CLINT: sel = tile_dev_pkg::DEV_CLINT;
        default:                      sel = tile_dev_pkg::DEV_LOOPBACK;
      endcase
  end

  // Output register is free when empty or handing off this cycle
  assign out_free    = ~(|dev_v_r) | (|(dev_v_r & dev_ready_i));
  assign cmd_ready_o = out_free & ord_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;

  assign ord_v_o   = cmd_v_i & out_free;
  assign ord_dev_o = sel;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      dev_v_r <= '0;
    else if (accept)
      dev_v_r <= 4'b0001 << sel;
    else if (out_free)
      dev_v_r <= '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      dev_cmd_o <= cmd_i;
  end

  assign dev_v_o = dev_v_r;

endmodule

//--- source/mem_loopback.sv
// Loopback responder
`timescale 1ns/1ps

module mem_loopback
  (input                            clk_i
   , input                          reset_i
   , input  tile_mem_pkg::mem_msg_s cmd_i
   , input                          cmd_v_i
   , output logic                   cmd_ready_o
   , output tile_mem_pkg::mem_msg_s resp_o
   , output logic                   resp_v_o
   , input                          resp_ready_i
   );

  tile_mem_pkg::mem_hdr_s hdr_r;
  logic                   accept;

  assign cmd_ready_o = ~resp_v_o | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_ready_i)
      resp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      hdr_r <= cmd_i.hdr;
  end

  assign resp_o = '{hdr: hdr_r, data: '0};

endmodule

//--- source/mem_resp_merge.sv
// In-order response merge
`timescale 1ns/1ps
`include "tile_cfg.svh"

module mem_resp_merge
  (input                                  clk_i
   , input                                reset_i
   , input                                ord_v_i
   , input  tile_dev_pkg::dev_id_e        ord_dev_i
   , output logic                         ord_ready_o
   , input  tile_mem_pkg::mem_msg_s [3:0] dev_resp_i
   , input  [3:0]                         dev_resp_v_i
   , output logic [3:0]                   dev_resp_ready_o
   , output tile_mem_pkg::mem_msg_s       resp_o
   , output logic                         resp_v_o
   , input                                resp_ready_i
   );

  localparam int DEPTH = `TILE_ORDER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  tile_dev_pkg::dev_id_e ord_mem [DEPTH];
  tile_dev_pkg::dev_id_e head;
  logic [PTR_W-1:0]      wptr;
  logic [PTR_W-1:0]      rptr;
  logic [CNT_W-1:0]      count;
  logic                  push;
  logic                  pop;
  logic                  empty;

  assign empty       = (count == '0);
  assign ord_ready_o = (count != CNT_W'(DEPTH));
  assign push        = ord_v_i & ord_ready_o;
  assign head        = ord_mem[rptr];

  // Only the device at the head of the order FIFO may answer
  assign resp_o   = dev_resp_i[head];
  assign resp_v_o = ~empty & dev_resp_v_i[head];
  assign pop      = resp_v_o & resp_ready_i;

  always_comb
  begin
    dev_resp_ready_o = '0;
    dev_resp_ready_o[head] = ~empty & resp_ready_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (pop)
        rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      ord_mem[wptr] <= ord_dev_i;
  end

endmodule

//--- source/tile_dev_pkg.sv
// Local device identifiers
`include "tile_cfg.svh"

package tile_dev_pkg;

  // Also the order FIFO entry
  typedef enum logic [1:0] {
    DEV_MEM      = 2'd0,
    DEV_CFG      = 2'd1,
    DEV_CLINT    = 2'd2,
    DEV_LOOPBACK = 2'd3
  } dev_id_e;

  // Device field codes in a local address
  localparam logic [`TILE_DEV_WIDTH-1:0] DEV_CODE_MEM   = 4'd0;
  localparam logic [`TILE_DEV_WIDTH-1:0] DEV_CODE_CFG   = 4'd1;
  localparam logic [`TILE_DEV_WIDTH-1:0] DEV_CODE_CLINT = 4'd2;

endpackage

//--- source/tile_mem_pkg.sv
// Memory network message types
`include "tile_cfg.svh"

package tile_mem_pkg;

  typedef enum logic [0:0] {
    MSG_RD = 1'b0,
    MSG_WR = 1'b1
  } msg_type_e;

  // Local device view of an address
  typedef struct packed {
    logic [`TILE_ADDR_WIDTH-`TILE_DEV_LSB-`TILE_DEV_WIDTH-1:0] unused;
    logic [`TILE_DEV_WIDTH-1:0]                                dev;
    logic [`TILE_OFFSET_WIDTH-1:0]                             offset;
  } local_addr_s;

  typedef union packed {
    logic [`TILE_ADDR_WIDTH-1:0] word;
    local_addr_s                 fields;
  } mem_addr_u;

  typedef struct packed {
    msg_type_e                  msg_type;
    logic [`TILE_TAG_WIDTH-1:0] tag;
    mem_addr_u                  addr;
  } mem_hdr_s;

  typedef struct packed {
    mem_hdr_s                    hdr;
    logic [`TILE_DATA_WIDTH-1:0] data;
  } mem_msg_s;

endpackage

//--- source/tile_mem_system.sv
// Tile memory command routing
`timescale 1ns/1ps
`include "tile_cfg.svh"

module tile_mem_system
  (input                                clk_i
   , input                              reset_i
   , input  tile_mem_pkg::mem_msg_s     cmd_i
   , input                              cmd_v_i
   , output logic                       cmd_ready_o
   , output tile_mem_pkg::mem_msg_s     resp_o
   , output logic                       resp_v_o
   , input                              resp_ready_i
   , output tile_mem_pkg::mem_msg_s     mem_cmd_o
   , output logic                       mem_cmd_v_o
   , input                              mem_cmd_ready_i
   , input  tile_mem_pkg::mem_msg_s     mem_resp_i
   , input                              mem_resp_v_i
   , output logic                       mem_resp_ready_o
   , input  [`TILE_DID_WIDTH-1:0]       my_did_i
   , output logic                       freeze_o
   , output logic [`TILE_DID_WIDTH-1:0] host_did_o
   , output logic                       timer_irq_o
   , output logic                       software_irq_o
   );

  tile_mem_pkg::mem_msg_s       dev_cmd;
  logic [3:0]                   dev_v;
  logic [3:0]                   dev_ready;
  tile_mem_pkg::mem_msg_s [3:0] dev_resp;
  logic [3:0]                   dev_resp_v;
  logic [3:0]                   dev_resp_ready;
  logic                         ord_v;
  logic                         ord_ready;
  tile_dev_pkg::dev_id_e        ord_dev;

  // Memory lane goes straight out of the tile
  assign mem_cmd_o   = dev_cmd;
  assign mem_cmd_v_o = dev_v[tile_dev_pkg::DEV_MEM];
  assign dev_ready[tile_dev_pkg::DEV_MEM]  = mem_cmd_ready_i;
  assign dev_resp[tile_dev_pkg::DEV_MEM]   = mem_resp_i;
  assign dev_resp_v[tile_dev_pkg::DEV_MEM] = mem_resp_v_i;
  assign mem_resp_ready_o = dev_resp_ready[tile_dev_pkg::DEV_MEM];

  mem_cmd_dispatch dispatch
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o)
     , .dev_cmd_o(dev_cmd), .dev_v_o(dev_v), .dev_ready_i(dev_ready)
     , .ord_v_o(ord_v), .ord_dev_o(ord_dev), .ord_ready_i(ord_ready)
     );

  cfg_regs cfg
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cmd_i(dev_cmd), .cmd_v_i(dev_v[tile_dev_pkg::DEV_CFG])
     , .cmd_ready_o(dev_ready[tile_dev_pkg::DEV_CFG])
     , .resp_o(dev_resp[tile_dev_pkg::DEV_CFG])
     , .resp_v_o(dev_resp_v[tile_dev_pkg::DEV_CFG])
     , .resp_ready_i(dev_resp_ready[tile_dev_pkg::DEV_CFG])
     , .my_did_i(my_did_i), .freeze_o(freeze_o), .host_did_o(host_did_o)
     );

  clint_slice clint
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cmd_i(dev_cmd), .cmd_v_i(dev_v[tile_dev_pkg::DEV_CLINT])
     , .cmd_ready_o(dev_ready[tile_dev_pkg::DEV_CLINT])
     , .resp_o(dev_resp[tile_dev_pkg::DEV_CLINT])
     , .resp_v_o(dev_resp_v[tile_dev_pkg::DEV_CLINT])
     , .resp_ready_i(dev_resp_ready[tile_dev_pkg::DEV_CLINT])
     , .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
     );

  mem_loopback loopback
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cmd_i(dev_cmd), .cmd_v_i(dev_v[tile_dev_pkg::DEV_LOOPBACK])
     , .cmd_ready_o(dev_ready[tile_dev_pkg::DEV_LOOPBACK])
     , .resp_o(dev_resp[tile_dev_pkg::DEV_LOOPBACK])
     , .resp_v_o(dev_resp_v[tile_dev_pkg::DEV_LOOPBACK])
     , .resp_ready_i(dev_resp_ready[tile_dev_pkg::DEV_LOOPBACK])
     );

  mem_resp_merge merge
    (.clk_i(clk_i), .reset_i(reset_i)
     , .ord_v_i(ord_v), .ord_dev_i(ord_dev), .ord_ready_o(ord_ready)
     , .dev_resp_i(dev_resp), .dev_resp_v_i(dev_resp_v)
     , .dev_resp_ready_o(dev_resp_ready)
     , .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i)
     );

endmodule

//--- testbench/tile_mem_system_tb.sv
// Tile memory system testbench
`timescale 1ns/1ps
`include "tile_cfg.svh"

module tile_mem_system_tb;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic                       clk_i = 1'b0;
  logic                       reset_i;
  tile_mem_pkg::mem_msg_s     cmd_i;
  logic                       cmd_v_i;
  logic                       cmd_ready_o;
  tile_mem_pkg::mem_msg_s     resp_o;
  logic                       resp_v_o;
  logic                       resp_ready_i;
  tile_mem_pkg::mem_msg_s     mem_cmd_o;
  logic                       mem_cmd_v_o;
  logic                       mem_cmd_ready_i;
  tile_mem_pkg::mem_msg_s     mem_resp_i;
  logic                       mem_resp_v_i;
  logic                       mem_resp_ready_o;
  logic [`TILE_DID_WIDTH-1:0] my_did_i;
  logic                       freeze_o;
  logic [`TILE_DID_WIDTH-1:0] host_did_o;
  logic                       timer_irq_o;
  logic                       software_irq_o;
  integer                     seed;

  tile_mem_system DUT (.*);

  always #50 clk_i = ~clk_i;

  initial
  begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("Testbench failed");
    $fatal(1, "Simulation timed out");
  end

  // Local address with the device field above the register offset
  function automatic logic [`TILE_ADDR_WIDTH-1:0] dev_addr
    (input logic [`TILE_DEV_WIDTH-1:0] dev, input logic [`TILE_OFFSET_WIDTH-1:0] offset);
    tile_mem_pkg::local_addr_s a;
    a.unused = '0;
    a.dev    = dev;
    a.offset = offset;
    return a;
  endfunction

  function automatic tile_mem_pkg::mem_msg_s make_cmd
    (input tile_mem_pkg::msg_type_e msg_type, input logic [`TILE_TAG_WIDTH-1:0] tag,
     input logic [`TILE_ADDR_WIDTH-1:0] addr, input logic [`TILE_DATA_WIDTH-1:0] data);
    tile_mem_pkg::mem_msg_s msg;
    msg.hdr.msg_type  = msg_type;
    msg.hdr.tag       = tag;
    msg.hdr.addr.word = addr;
    msg.data          = data;
    return msg;
  endfunction

  // Response echoes the command header
  function automatic tile_mem_pkg::mem_msg_s reply
    (input tile_mem_pkg::mem_msg_s cmd, input logic [`TILE_DATA_WIDTH-1:0] data);
    return '{hdr: cmd.hdr, data: data};
  endfunction

  function automatic logic [`TILE_DATA_WIDTH-1:0] rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_msg(input string name, input tile_mem_pkg::mem_msg_s exp,
                           input tile_mem_pkg::mem_msg_s act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "Message mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "Output bit mismatch");
    end
  endtask

  task automatic check_did(input string name, input logic [`TILE_DID_WIDTH-1:0] exp,
                           input logic [`TILE_DID_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "Domain id mismatch");
    end
  endtask

  task automatic send_cmd(input tile_mem_pkg::mem_msg_s msg);
    @(negedge clk_i);
    cmd_i   = msg;
    cmd_v_i = 1'b1;
    #1;
    while (!cmd_ready_o)
    begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    cmd_v_i = 1'b0;
  endtask

  task automatic get_resp(output tile_mem_pkg::mem_msg_s msg);
    @(negedge clk_i);
    resp_ready_i = 1'b1;
    #1;
    while (!resp_v_o)
    begin
      @(negedge clk_i);
      #1;
    end
    msg = resp_o;
    @(negedge clk_i);
    resp_ready_i = 1'b0;
  endtask

  task automatic get_mem_cmd(output tile_mem_pkg::mem_msg_s msg);
    @(negedge clk_i);
    mem_cmd_ready_i = 1'b1;
    #1;
    while (!mem_cmd_v_o)
    begin
      @(negedge clk_i);
      #1;
    end
    msg = mem_cmd_o;
    @(negedge clk_i);
    mem_cmd_ready_i = 1'b0;
  endtask

  // Memory response must be at the head of the order FIFO
  task automatic return_mem_resp(input tile_mem_pkg::mem_msg_s msg,
                                 output tile_mem_pkg::mem_msg_s got);
    @(negedge clk_i);
    mem_resp_i   = msg;
    mem_resp_v_i = 1'b1;
    #1;
    check_bit("mem_resp_stall", 1'b0, mem_resp_ready_o);
    @(negedge clk_i);
    resp_ready_i = 1'b1;
    #1;
    // Merge is combinational from the head device
    check_bit("mem_resp_valid", 1'b1, resp_v_o);
    check_bit("mem_resp_ready", 1'b1, mem_resp_ready_o);
    got = resp_o;
    @(negedge clk_i);
    resp_ready_i = 1'b0;
    mem_resp_v_i = 1'b0;
  endtask

  task automatic access(input tile_mem_pkg::mem_msg_s cmd, output tile_mem_pkg::mem_msg_s got);
    send_cmd(cmd);
    get_resp(got);
  endtask

  task automatic test_cfg();
    tile_mem_pkg::mem_msg_s      cmd;
    tile_mem_pkg::mem_msg_s      got;
    logic [`TILE_DATA_WIDTH-1:0] did_data;
    check_bit("cfg_reset_freeze", 1'b1, freeze_o);
    check_bit("cfg_reset_ready", 1'b1, cmd_ready_o);
    check_bit("cfg_reset_resp_v", 1'b0, resp_v_o);
    cmd = make_cmd(tile_mem_pkg::MSG_WR, 4'h1,
                   dev_addr(tile_dev_pkg::DEV_CODE_CFG, `TILE_CFG_FREEZE), '0);
    access(cmd, got);
    check_msg("cfg_freeze_wr", reply(cmd, '0), got);
    check_bit("cfg_freeze_clear", 1'b0, freeze_o);
    did_data = rand_data();
    cmd = make_cmd(tile_mem_pkg::MSG_WR, 4'h2,
                   dev_addr(tile_dev_pkg::DEV_CODE_CFG, `TILE_CFG_HOST_DID), did_data);
    access(cmd, got);
    check_msg("cfg_host_did_wr", reply(cmd, '0), got);
    cmd = make_cmd(tile_mem_pkg::MSG_RD, 4'h3,
                   dev_addr(tile_dev_pkg::DEV_CODE_CFG, `TILE_CFG_HOST_DID), '0);
    access(cmd, got);
    check_msg("cfg_host_did_rd",
              reply(cmd, `TILE_DATA_WIDTH'(did_data[`TILE_DID_WIDTH-1:0])), got);
    check_did("cfg_host_did_out", did_data[`TILE_DID_WIDTH-1:0], host_did_o);
    cmd = make_cmd(tile_mem_pkg::MSG_RD, 4'h4,
                   dev_addr(tile_dev_pkg::DEV_CODE_CFG, `TILE_CFG_MY_DID), '0);
    access(cmd, got);
    check_msg("cfg_my_did_rd", reply(cmd, `TILE_DATA_WIDTH'(my_did_i)), got);
  endtask

  task automatic test_clint();
    tile_mem_pkg::mem_msg_s cmd;
    tile_mem_pkg::mem_msg_s got;
    cmd = make_cmd(tile_mem_pkg::MSG_WR, 4'h5,
                   dev_addr(tile_dev_pkg::DEV_CODE_CLINT, `TILE_CLINT_MSIP), 64'd1);
    access(cmd, got);
    check_msg("clint_msip_set", reply(cmd, '0), got);
    check_bit("clint_sw_irq_set", 1'b1, software_irq_o);
    cmd.data = '0;
    access(cmd, got);
    check_bit("clint_sw_irq_clear", 1'b0, software_irq_o);
    cmd = make_cmd(tile_mem_pkg::MSG_WR, 4'h6,
                   dev_addr(tile_dev_pkg::DEV_CODE_CLINT, `TILE_CLINT_MTIMECMP), '0);
    access(cmd, got);
    check_msg("clint_mtimecmp_wr", reply(cmd, '0), got);
    check_bit("clint_timer_irq_set", 1'b1, timer_irq_o);
    // Zero differs from the reset value
    cmd.hdr.msg_type = tile_mem_pkg::MSG_RD;
    access(cmd, got);
    check_msg("clint_mtimecmp_rd", reply(cmd, '0), got);
    cmd.hdr.msg_type = tile_mem_pkg::MSG_WR;
    cmd.data         = '1;
    access(cmd, got);
    check_bit("clint_timer_irq_clear", 1'b0, timer_irq_o);
  endtask

  task automatic test_mem();
    tile_mem_pkg::mem_msg_s cmd;
    tile_mem_pkg::mem_msg_s resp;
    tile_mem_pkg::mem_msg_s got;
    cmd = make_cmd(tile_mem_pkg::MSG_WR, 4'h7, 32'h9000_1230, rand_data());
    send_cmd(cmd);
    get_mem_cmd(got);
    check_msg("mem_dram_cmd", cmd, got);
    resp = reply(cmd, rand_data());
    return_mem_resp(resp, got);
    check_msg("mem_dram_resp", resp, got);
    cmd = make_cmd(tile_mem_pkg::MSG_RD, 4'h8,
                   dev_addr(tile_dev_pkg::DEV_CODE_MEM, 20'h0_1240), '0);
    send_cmd(cmd);
    get_mem_cmd(got);
    check_msg("mem_dev0_cmd", cmd, got);
    resp = reply(cmd, rand_data());
    return_mem_resp(resp, got);
    check_msg("mem_dev0_resp", resp, got);
  endtask

  task automatic test_loopback();
    tile_mem_pkg::mem_msg_s cmd;
    tile_mem_pkg::mem_msg_s got;
    cmd = make_cmd(tile_mem_pkg::MSG_RD, 4'h9, dev_addr(4'd5, 20'h0_0100), '0);
    access(cmd, got);
    check_msg("loopback_rd", reply(cmd, '0), got);
    cmd = make_cmd(tile_mem_pkg::MSG_WR, 4'hA, dev_addr(4'd5, 20'h0_0108), rand_data());
    access(cmd, got);
    check_msg("loopback_wr", reply(cmd, '0), got);
  endtask

  task automatic test_order();
    tile_mem_pkg::mem_msg_s mem_cmd;
    tile_mem_pkg::mem_msg_s cfg_cmd;
    tile_mem_pkg::mem_msg_s lb_cmd;
    tile_mem_pkg::mem_msg_s clint_cmd;
    tile_mem_pkg::mem_msg_s mem_resp;
    tile_mem_pkg::mem_msg_s got;
    mem_cmd   = make_cmd(tile_mem_pkg::MSG_RD, 4'hB, 32'hA000_0040, '0);
    cfg_cmd   = make_cmd(tile_mem_pkg::MSG_RD, 4'hC,
                         dev_addr(tile_dev_pkg::DEV_CODE_CFG, `TILE_CFG_MY_DID), '0);
    lb_cmd    = make_cmd(tile_mem_pkg::MSG_WR, 4'hD, dev_addr(4'd5, 20'h0_0200), rand_data());
    clint_cmd = make_cmd(tile_mem_pkg::MSG_RD, 4'hE,
                         dev_addr(tile_dev_pkg::DEV_CODE_CLINT, `TILE_CLINT_MTIMECMP), '0);
    send_cmd(mem_cmd);
    get_mem_cmd(got);
    check_msg("order_mem_cmd", mem_cmd, got);
    send_cmd(cfg_cmd);
    send_cmd(lb_cmd);
    send_cmd(clint_cmd);
    // Four in flight fill the order FIFO
    check_bit("order_fifo_full", 1'b0, cmd_ready_o);
    repeat (6) @(negedge clk_i);
    check_bit("order_head_wait", 1'b0, resp_v_o);
    mem_resp = reply(mem_cmd, rand_data());
    return_mem_resp(mem_resp, got);
    check_msg("order_resp_mem", mem_resp, got);
    get_resp(got);
    check_msg("order_resp_cfg", reply(cfg_cmd, `TILE_DATA_WIDTH'(my_did_i)), got);
    get_resp(got);
    check_msg("order_resp_loopback", reply(lb_cmd, '0), got);
    get_resp(got);
    check_msg("order_resp_clint", reply(clint_cmd, '1), got);
  endtask

  initial
  begin
    seed            = 1;
    reset_i         = 1'b1;
    cmd_i           = '0;
    cmd_v_i         = 1'b0;
    resp_ready_i    = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    my_did_i        = 3'd5;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_cfg();
    test_clint();
    test_mem();
    test_loopback();
    test_order();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- tile_mem_system.f
+incdir+include
source/tile_mem_pkg.sv
source/tile_dev_pkg.sv
source/mem_cmd_dispatch.sv
source/cfg_regs.sv
source/clint_slice.sv
source/mem_loopback.sv
source/mem_resp_merge.sv
source/tile_mem_system.sv
testbench/tile_mem_system_tb.sv
